/* dv/lane_cases.txt */
# L reg idx value(hex) | R reg count | I op vd vs1 vs2 vl  (op 0 add 1 sub 2 and 3 or 4 xor)
# S reg vl n v0 .. v(n-1): first n values expected literally, the rest from the model
L 0 0 00000001
L 0 1 ffffffff
L 0 2 80000000
L 0 3 12345678
L 0 4 deadbeef
L 0 5 0000a5a5
S 0 6 6 00000001 ffffffff 80000000 12345678 deadbeef 0000a5a5
R 1 16
R 2 16
I 0 3 1 2 16
S 3 16 0
I 1 4 1 2 16
S 4 16 0
I 2 5 1 2 16
S 5 16 0
I 3 6 1 2 16
S 6 16 0
I 4 7 1 2 16
S 7 16 0
I 0 3 0 0 2
S 3 4 2 00000002 fffffffe
I 1 4 2 1 5
S 4 16 0
I 0 2 2 2 16
S 2 16 0
I 4 1 1 1 16
S 1 16 3 00000000 00000000 00000000
I 0 5 1 2 0
S 5 16 0
S 0 0 0

/* dv/lane_tb.sv */
/* Reads dv/lane_cases.txt from the project root. Loads, instructions and stores run one
   at a time, and register contents are tracked by a shadow model. */
`timescale 1ns/1ps

module lane_tb import lane_pkg::*; ();

  localparam int DoneTimeout = 150;
  localparam int CyclesPerLine = 200;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      req_valid_i, ld_valid_i;
  vop_e      req_op_i;
  vreg_t     req_vd_i, req_vs1_i, req_vs2_i, ld_reg_i;
  vl_t       req_vl_i;
  elem_idx_t ld_idx_i;
  elem_t     ld_data_i;
  logic      done_o, st_valid_o, busy_o;
  elem_t     st_data_o;

  elem_t       model [NrVRegs][MaxVl];
  elem_t       st_seen [$];
  logic [15:0] lfsr_state = 16'd17;
  int          value_errs = 0;
  int          count_errs = 0;
  int          flag_errs = 0;
  int          other_errs = 0;
  int          limit_cycles = 0;

  lane uut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_elem(string name, elem_t got, elem_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(string name, vl_t got, vl_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
      count_errs++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      flag_errs++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Result is vs2 op vs1 and sums wrap at 32 bits
  function automatic elem_t model_op(vop_e op, elem_t b, elem_t a);
    case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      VXOR:    return b ^ a;
      default: return b;
    endcase
  endfunction

  task automatic load_elem(int r, int idx, elem_t data);
    @(posedge clk_i);
    ld_valid_i <= 1'b1;
    ld_reg_i   <= vreg_t'(r);
    ld_idx_i   <= elem_idx_t'(idx);
    ld_data_i  <= data;
    model[r][idx] = data;
    @(posedge clk_i);
    ld_valid_i <= 1'b0;
  endtask

  // One LFSR step per bit of each element
  task automatic fill_reg(int r, int count);
    elem_t word;
    for (int i = 0; i < count; i++) begin
      word = '0;
      for (int k = 0; k < ElemWidth; k++) begin
        word       = {word[ElemWidth-2:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
      end
      load_elem(r, i, word);
    end
  endtask

  // Issues one instruction, collects store data, waits for done_o
  task automatic run_instr(vop_e op, int vd, int vs1, int vs2, int vl);
    int   n;
    logic done_seen;
    n         = 0;
    done_seen = 1'b0;
    st_seen.delete();
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_vd_i    <= vreg_t'(vd);
    req_vs1_i   <= vreg_t'(vs1);
    req_vs2_i   <= vreg_t'(vs2);
    req_vl_i    <= vl_t'(vl);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (!done_seen && n < DoneTimeout) begin
      @(negedge clk_i);
      n++;
      if (st_valid_o) st_seen.push_back(st_data_o);
      if (done_o) done_seen = 1'b1;
      else check_flag("busy_o", busy_o, 1'b1);
    end
    if (!done_seen) begin
      $display("Instruction %s did not finish, no done_o within %0d cycles",
               op.name(), DoneTimeout);
      other_errs++;
    end
    check_count("st_valid_o count", vl_t'(st_seen.size()),
                (op == VSTORE) ? vl_t'(vl) : vl_t'(0));
    if (vl == 0) check_count("done_o latency", vl_t'(n), vl_t'(2));
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    if (op != VSTORE) begin
      for (int i = 0; i < vl; i++) model[vd][i] = model_op(op, model[vs2][i], model[vs1][i]);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          fd, rc, nlines, r, idx, cnt, vl, op, vd, vs1, vs2;
    logic [7:0]  kind;
    string       line;
    elem_t       data;
    elem_t       lit [MaxVl];
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = VADD;
    req_vd_i    = '0;
    req_vs1_i   = '0;
    req_vs2_i   = '0;
    req_vl_i    = '0;
    ld_valid_i  = 1'b0;
    ld_reg_i    = '0;
    ld_idx_i    = '0;
    ld_data_i   = '0;
    nlines      = 0;
    fd = $fopen("dv/lane_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file dv/lane_cases.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        nlines++;
      end
      $fclose(fd);
      limit_cycles = (nlines + 1) * CyclesPerLine;
      fd = $fopen("dv/lane_cases.txt", "r");
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": rc = $fgets(line, fd);
        "L": begin
          rc = $fscanf(fd, "%d %d %h", r, idx, data);
          load_elem(r, idx, data);
        end
        "R": begin
          rc = $fscanf(fd, "%d %d", r, cnt);
          fill_reg(r, cnt);
        end
        "I": begin
          rc = $fscanf(fd, "%d %d %d %d %d", op, vd, vs1, vs2, vl);
          run_instr(vop_e'(op), vd, vs1, vs2, vl);
        end
        "S": begin
          rc = $fscanf(fd, "%d %d %d", r, vl, cnt);
          for (int k = 0; k < cnt && k < MaxVl; k++) rc = $fscanf(fd, "%h", lit[k]);
          run_instr(VSTORE, 0, 0, r, vl);
          for (int k = 0; k < st_seen.size() && k < vl; k++) begin
            check_elem($sformatf("st_data_o[%0d]", k), st_seen[k],
                       (k < cnt) ? lit[k] : model[r][k]);
          end
        end
        default: begin
          $display("Unknown line kind '%c' in the cases file", kind);
          other_errs++;
          rc = $fgets(line, fd);
        end
      endcase
    end
    if (fd != 0) $fclose(fd);
    $display("Errors: value %0d, count %0d, flag %0d, other %0d",
             value_errs, count_errs, flag_errs, other_errs);
    if (value_errs + count_errs + flag_errs + other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of case lines
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the lane testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module lane_tb \
  -Mdir obj_dir -o lane_sim && ./obj_dir/lane_sim > sim.log
cat sim.log 2>/dev/null
grep -q '^RESULT: PASS$' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* src/lane.sv */
/* One vector lane with a single instruction in flight. Issue only after done_o and
   load only while busy_o is low, since no input is back-pressured. */
`timescale 1ns/1ps

module lane import lane_pkg::*; #(
  parameter int unsigned NrBanks    = lane_pkg::NrBanks,
  parameter int unsigned QueueDepth = lane_pkg::QueueDepth
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  input  vop_e      req_op_i,
  input  vreg_t     req_vd_i,
  input  vreg_t     req_vs1_i,
  input  vreg_t     req_vs2_i,
  input  vl_t       req_vl_i,
  input  logic      ld_valid_i,
  input  vreg_t     ld_reg_i,
  input  elem_idx_t ld_idx_i,
  input  elem_t     ld_data_i,
  output logic      done_o,
  output logic      st_valid_o,
  output elem_t     st_data_o,
  output logic      busy_o
);

  logic  fetch_start, fetch_need_a, alu_start, alu_done;
  vreg_t fetch_vs1, fetch_vs2, alu_vd;
  vl_t   fetch_vl, alu_vl;
  vop_e  alu_op;

  logic  [NrBanks-1:0] vrf_req, vrf_wen;
  row_t  [NrBanks-1:0] vrf_row;
  elem_t [NrBanks-1:0] vrf_wdata;
  opq_e  [NrBanks-1:0] vrf_tgt;

  elem_t [1:0] rdata;
  logic  [1:0] rdata_valid;
  opq_e  [1:0] rdata_tgt;

  elem_t opa, opb;
  logic  opa_valid, opb_valid, alu_pop_a, alu_pop_b, q_pop_a, q_pop_b;

  vrf_req_if ld_if ();
  vrf_req_if wb_if ();
  vrf_req_if rd_a_if ();
  vrf_req_if rd_b_if ();

  // Load port, granted at once by its top priority
  assign ld_if.req   = ld_valid_i;
  assign ld_if.wen   = 1'b1;
  assign ld_if.bank  = bank_of(ld_reg_i, ld_idx_i);
  assign ld_if.row   = row_of(ld_reg_i, ld_idx_i);
  assign ld_if.wdata = ld_data_i;
  assign ld_if.tgt   = OPQ_A;

  lane_sequencer i_sequencer (
    .clk_i          (clk_i       ),
    .rst_ni         (rst_ni      ),
    .req_valid_i    (req_valid_i ),
    .req_op_i       (req_op_i    ),
    .req_vd_i       (req_vd_i    ),
    .req_vs1_i      (req_vs1_i   ),
    .req_vs2_i      (req_vs2_i   ),
    .req_vl_i       (req_vl_i    ),
    .alu_done_i     (alu_done    ),
    .fetch_start_o  (fetch_start ),
    .fetch_need_a_o (fetch_need_a),
    .fetch_vs1_o    (fetch_vs1   ),
    .fetch_vs2_o    (fetch_vs2   ),
    .fetch_vl_o     (fetch_vl    ),
    .alu_start_o    (alu_start   ),
    .alu_op_o       (alu_op      ),
    .alu_vd_o       (alu_vd      ),
    .alu_vl_o       (alu_vl      ),
    .busy_o         (busy_o      ),
    .done_o         (done_o      )
  );

  operand_requester #(
    .NrBanks    (NrBanks   ),
    .QueueDepth (QueueDepth)
  ) i_requester (
    .clk_i          (clk_i       ),
    .rst_ni         (rst_ni      ),
    .fetch_start_i  (fetch_start ),
    .fetch_need_a_i (fetch_need_a),
    .fetch_vs1_i    (fetch_vs1   ),
    .fetch_vs2_i    (fetch_vs2   ),
    .fetch_vl_i     (fetch_vl    ),
    .pop_a_i        (q_pop_a     ),
    .pop_b_i        (q_pop_b     ),
    .ld             (ld_if       ),
    .wb             (wb_if       ),
    .rd_a           (rd_a_if     ),
    .rd_b           (rd_b_if     ),
    .rd_a_arb       (rd_a_if     ),
    .rd_b_arb       (rd_b_if     ),
    .vrf_req_o      (vrf_req     ),
    .vrf_wen_o      (vrf_wen     ),
    .vrf_row_o      (vrf_row     ),
    .vrf_wdata_o    (vrf_wdata   ),
    .vrf_tgt_o      (vrf_tgt     )
  );

  vector_regfile #(
    .NrBanks (NrBanks)
  ) i_vrf (
    .clk_i         (clk_i      ),
    .rst_ni        (rst_ni     ),
    .req_i         (vrf_req    ),
    .wen_i         (vrf_wen    ),
    .row_i         (vrf_row    ),
    .wdata_i       (vrf_wdata  ),
    .tgt_i         (vrf_tgt    ),
    .rdata_o       (rdata      ),
    .rdata_valid_o (rdata_valid),
    .rdata_tgt_o   (rdata_tgt  )
  );

  operand_queues #(
    .QueueDepth (QueueDepth)
  ) i_queues (
    .clk_i         (clk_i      ),
    .rst_ni        (rst_ni     ),
    .rdata_i       (rdata      ),
    .rdata_valid_i (rdata_valid),
    .rdata_tgt_i   (rdata_tgt  ),
    .pop_a_i       (alu_pop_a  ),
    .pop_b_i       (alu_pop_b  ),
    .opa_o         (opa        ),
    .opb_o         (opb        ),
    .opa_valid_o   (opa_valid  ),
    .opb_valid_o   (opb_valid  ),
    .pop_a_o       (q_pop_a    ),
    .pop_b_o       (q_pop_b    )
  );

  vector_alu i_alu (
    .clk_i       (clk_i     ),
    .rst_ni      (rst_ni    ),
    .alu_start_i (alu_start ),
    .alu_op_i    (alu_op    ),
    .alu_vd_i    (alu_vd    ),
    .alu_vl_i    (alu_vl    ),
    .opa_i       (opa       ),
    .opb_i       (opb       ),
    .opa_valid_i (opa_valid ),
    .opb_valid_i (opb_valid ),
    .pop_a_o     (alu_pop_a ),
    .pop_b_o     (alu_pop_b ),
    .alu_done_o  (alu_done  ),
    .st_valid_o  (st_valid_o),
    .st_data_o   (st_data_o ),
    .wb          (wb_if     )
  );

endmodule

/* src/lane_pkg.sv */
/* Widths, types and the element address map of the lane. bank_t and row_t follow the
   NrBanks value here, so a lane built with another bank count needs it changed to match. */
package lane_pkg;

  localparam int unsigned ElemWidth  = 32;
  localparam int unsigned NrVRegs    = 8;
  localparam int unsigned MaxVl      = 16;
  localparam int unsigned NrBanks    = 4;
  localparam int unsigned QueueDepth = 4;

  typedef logic [ElemWidth-1:0]                     elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]               vreg_t;
  typedef logic [$clog2(MaxVl+1)-1:0]               vl_t;
  typedef logic [$clog2(MaxVl)-1:0]                 elem_idx_t;
  typedef logic [$clog2(NrBanks)-1:0]               bank_t;
  typedef logic [$clog2(NrVRegs*MaxVl/NrBanks)-1:0] row_t;

  // Result is vs2 op vs1; VSTORE streams vs2 out
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } vop_e;

  typedef enum logic {
    OPQ_A = 1'b0,
    OPQ_B = 1'b1
  } opq_e;

  // Elements are interleaved over the banks by word address
  function automatic bank_t bank_of(vreg_t vreg, elem_idx_t idx);
    int unsigned addr;
    addr = vreg * MaxVl + idx;
    return bank_t'(addr % NrBanks);
  endfunction

  function automatic row_t row_of(vreg_t vreg, elem_idx_t idx);
    int unsigned addr;
    addr = vreg * MaxVl + idx;
    return row_t'(addr / NrBanks);
  endfunction

endpackage

/* src/lane_sequencer.sv */
/* Takes one instruction at a time and drops requests while busy. An instruction with
   vl of 0 does no work and reports done two cycles after the request. */
`timescale 1ns/1ps

module lane_sequencer import lane_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_valid_i,
  input  vop_e  req_op_i,
  input  vreg_t req_vd_i,
  input  vreg_t req_vs1_i,
  input  vreg_t req_vs2_i,
  input  vl_t   req_vl_i,
  input  logic  alu_done_i,
  output logic  fetch_start_o,
  output logic  fetch_need_a_o,
  output vreg_t fetch_vs1_o,
  output vreg_t fetch_vs2_o,
  output vl_t   fetch_vl_o,
  output logic  alu_start_o,
  output vop_e  alu_op_o,
  output vreg_t alu_vd_o,
  output vl_t   alu_vl_o,
  output logic  busy_o,
  output logic  done_o
);

  typedef enum logic {IDLE, RUN} state_e;

  state_e state_q;
  logic   zero_q;
  logic   accept;
  vop_e   op_q;
  vreg_t  vd_q, vs1_q, vs2_q;
  vl_t    vl_q;

  assign accept = req_valid_i && (state_q == IDLE) && !zero_q;
  assign busy_o = (state_q == RUN) || zero_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      zero_q        <= 1'b0;
      fetch_start_o <= 1'b0;
      alu_start_o   <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      // Fetch and ALU start together, one cycle after the request
      fetch_start_o <= accept && (req_vl_i != '0);
      alu_start_o   <= accept && (req_vl_i != '0);
      zero_q        <= accept && (req_vl_i == '0);
      done_o        <= zero_q || ((state_q == RUN) && alu_done_i);
      unique case (state_q)
        IDLE: if (accept && (req_vl_i != '0)) state_q <= RUN;
        RUN:  if (alu_done_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= req_op_i;
      vd_q  <= req_vd_i;
      vs1_q <= req_vs1_i;
      vs2_q <= req_vs2_i;
      vl_q  <= req_vl_i;
    end
  end

  // Stores only read vs2, on stream B
  assign fetch_need_a_o = (op_q != VSTORE);
  assign fetch_vs1_o    = vs1_q;
  assign fetch_vs2_o    = vs2_q;
  assign fetch_vl_o     = vl_q;
  assign alu_op_o       = op_q;
  assign alu_vd_o       = vd_q;
  assign alu_vl_o       = vl_q;

endmodule

/* src/operand_queues.sv */
/* Two operand FIFOs, A and B, filled by tag from the VRF read lanes. No full check,
   the requester credits keep each queue within QueueDepth. */
`timescale 1ns/1ps

module operand_queues import lane_pkg::*; #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  elem_t [1:0] rdata_i,
  input  logic  [1:0] rdata_valid_i,
  input  opq_e  [1:0] rdata_tgt_i,
  input  logic        pop_a_i,
  input  logic        pop_b_i,
  output elem_t       opa_o,
  output elem_t       opb_o,
  output logic        opa_valid_o,
  output logic        opb_valid_o,
  output logic        pop_a_o,
  output logic        pop_b_o
);

  typedef logic [$clog2(QueueDepth)-1:0]   ptr_t;
  typedef logic [$clog2(QueueDepth+1)-1:0] cnt_t;

  logic  [1:0] pop, push, valid;
  elem_t [1:0] push_data, head;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(QueueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = {pop_b_i, pop_a_i} & valid;

  always_comb begin
    push      = '0;
    push_data = '0;
    for (int l = 0; l < 2; l++) begin
      if (rdata_valid_i[l]) begin
        push[rdata_tgt_i[l]]      = 1'b1;
        push_data[rdata_tgt_i[l]] = rdata_i[l];
      end
    end
  end

  for (genvar q = 0; q < 2; q++) begin : gen_fifo
    elem_t mem_q [QueueDepth];
    ptr_t  wptr_q, rptr_q;
    cnt_t  cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wptr_q <= '0;
        rptr_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (push[q]) wptr_q <= next_ptr(wptr_q);
        if (pop[q])  rptr_q <= next_ptr(rptr_q);
        cnt_q <= cnt_q + cnt_t'(push[q]) - cnt_t'(pop[q]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[q]) mem_q[wptr_q] <= push_data[q];
    end

    assign valid[q] = (cnt_q != '0);
    assign head[q]  = mem_q[rptr_q];
  end

  assign opa_o       = head[0];
  assign opb_o       = head[1];
  assign opa_valid_o = valid[0];
  assign opb_valid_o = valid[1];
  assign pop_a_o     = pop[0];
  assign pop_b_o     = pop[1];

endmodule

/* src/operand_requester.sv */
/* Fixed priority per bank is load, writeback, read A, read B. A read stream stops
   issuing once QueueDepth of its elements are granted but not yet popped. */
`timescale 1ns/1ps

module operand_requester import lane_pkg::*; #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_start_i,
  input  logic                fetch_need_a_i,
  input  vreg_t               fetch_vs1_i,
  input  vreg_t               fetch_vs2_i,
  input  vl_t                 fetch_vl_i,
  input  logic                pop_a_i,
  input  logic                pop_b_i,
  vrf_req_if.arbiter          ld,
  vrf_req_if.arbiter          wb,
  vrf_req_if.client           rd_a,
  vrf_req_if.client           rd_b,
  vrf_req_if.arbiter          rd_a_arb,
  vrf_req_if.arbiter          rd_b_arb,
  output logic  [NrBanks-1:0] vrf_req_o,
  output logic  [NrBanks-1:0] vrf_wen_o,
  output row_t  [NrBanks-1:0] vrf_row_o,
  output elem_t [NrBanks-1:0] vrf_wdata_o,
  output opq_e  [NrBanks-1:0] vrf_tgt_o
);

  typedef logic [$clog2(QueueDepth+1)-1:0] cnt_t;

  vreg_t      src_q [2];
  vl_t        vl_q;
  logic [1:0] active_q, stream_req, stream_gnt, pop;
  elem_idx_t  idx_q [2];
  cnt_t       cnt_q [2];

  ////////////////////////////////////////
  // Read streams
  ////////////////////////////////////////

  assign pop        = {pop_b_i, pop_a_i};
  assign stream_gnt = {rd_b.gnt, rd_a.gnt};

  always_ff @(posedge clk_i) begin
    if (fetch_start_i) begin
      src_q[0] <= fetch_vs1_i;
      src_q[1] <= fetch_vs2_i;
      vl_q     <= fetch_vl_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= '0;
      for (int s = 0; s < 2; s++) begin
        idx_q[s] <= '0;
        cnt_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (fetch_start_i) begin
          active_q[s] <= (fetch_vl_i != '0) && ((s == 1) || fetch_need_a_i);
          idx_q[s]    <= '0;
        end else if (stream_gnt[s]) begin
          idx_q[s] <= idx_q[s] + 1'b1;
          if ((vl_t'(idx_q[s]) + vl_t'(1)) == vl_q) active_q[s] <= 1'b0;
        end
        // Credits count elements granted but not yet popped
        cnt_q[s] <= cnt_q[s] + cnt_t'(stream_gnt[s]) - cnt_t'(pop[s]);
      end
    end
  end

  for (genvar s = 0; s < 2; s++) begin : gen_req
    assign stream_req[s] = active_q[s] && (cnt_q[s] < cnt_t'(QueueDepth));
  end

  assign rd_a.req   = stream_req[0];
  assign rd_a.wen   = 1'b0;
  assign rd_a.bank  = bank_of(src_q[0], idx_q[0]);
  assign rd_a.row   = row_of(src_q[0], idx_q[0]);
  assign rd_a.wdata = '0;
  assign rd_a.tgt   = OPQ_A;

  assign rd_b.req   = stream_req[1];
  assign rd_b.wen   = 1'b0;
  assign rd_b.bank  = bank_of(src_q[1], idx_q[1]);
  assign rd_b.row   = row_of(src_q[1], idx_q[1]);
  assign rd_b.wdata = '0;
  assign rd_b.tgt   = OPQ_B;

  ////////////////////////////////////////
  // Bank arbitration
  ////////////////////////////////////////

  // Client 0 has the highest priority
  logic  [3:0] c_req, c_wen, c_gnt;
  bank_t [3:0] c_bank;
  row_t  [3:0] c_row;
  elem_t [3:0] c_wdata;
  opq_e  [3:0] c_tgt;

  assign c_req   = {rd_b_arb.req, rd_a_arb.req, wb.req, ld.req};
  assign c_wen   = {rd_b_arb.wen, rd_a_arb.wen, wb.wen, ld.wen};
  assign c_bank  = {rd_b_arb.bank, rd_a_arb.bank, wb.bank, ld.bank};
  assign c_row   = {rd_b_arb.row, rd_a_arb.row, wb.row, ld.row};
  assign c_wdata = {rd_b_arb.wdata, rd_a_arb.wdata, wb.wdata, ld.wdata};
  assign c_tgt[0] = ld.tgt;
  assign c_tgt[1] = wb.tgt;
  assign c_tgt[2] = rd_a_arb.tgt;
  assign c_tgt[3] = rd_b_arb.tgt;

  always_comb begin
    logic taken;
    c_gnt       = '0;
    vrf_req_o   = '0;
    vrf_wen_o   = '0;
    vrf_row_o   = '0;
    vrf_wdata_o = '0;
    for (int b = 0; b < NrBanks; b++) begin
      vrf_tgt_o[b] = OPQ_A;
      taken        = 1'b0;
      for (int c = 0; c < 4; c++) begin
        if (!taken && c_req[c] && (c_bank[c] == bank_t'(b))) begin
          taken          = 1'b1;
          c_gnt[c]       = 1'b1;
          vrf_req_o[b]   = 1'b1;
          vrf_wen_o[b]   = c_wen[c];
          vrf_row_o[b]   = c_row[c];
          vrf_wdata_o[b] = c_wdata[c];
          vrf_tgt_o[b]   = c_tgt[c];
        end
      end
    end
  end

  assign ld.gnt       = c_gnt[0];
  assign wb.gnt       = c_gnt[1];
  assign rd_a_arb.gnt = c_gnt[2];
  assign rd_b_arb.gnt = c_gnt[3];

endmodule

/* src/vector_alu.sv */
/* One result is held for writeback at a time. Stores pop queue B every cycle it has
   data and emit the element a cycle later. */
`timescale 1ns/1ps

module vector_alu import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      alu_start_i,
  input  vop_e      alu_op_i,
  input  vreg_t     alu_vd_i,
  input  vl_t       alu_vl_i,
  input  elem_t     opa_i,
  input  elem_t     opb_i,
  input  logic      opa_valid_i,
  input  logic      opb_valid_i,
  output logic      pop_a_o,
  output logic      pop_b_o,
  output logic      alu_done_o,
  output logic      st_valid_o,
  output elem_t     st_data_o,
  vrf_req_if.client wb
);

  logic  active_q, last_q, wb_req_q, pop, is_store;
  vop_e  op_q;
  vreg_t vd_q;
  vl_t   vl_q, pop_cnt_q;
  bank_t wb_bank_q;
  row_t  wb_row_q;
  elem_t wb_data_q, result;

  assign is_store = (op_q == VSTORE);
  assign pop      = active_q && (pop_cnt_q != vl_q) && opb_valid_i &&
                    (is_store || (opa_valid_i && !wb_req_q));
  assign pop_a_o  = pop && !is_store;
  assign pop_b_o  = pop;

  // B holds vs2, A holds vs1
  always_comb begin
    unique case (op_q)
      VADD:    result = opb_i + opa_i;
      VSUB:    result = opb_i - opa_i;
      VAND:    result = opb_i & opa_i;
      VOR:     result = opb_i | opa_i;
      VXOR:    result = opb_i ^ opa_i;
      default: result = opb_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      last_q     <= 1'b0;
      wb_req_q   <= 1'b0;
      pop_cnt_q  <= '0;
      st_valid_o <= 1'b0;
      alu_done_o <= 1'b0;
    end else begin
      st_valid_o <= pop && is_store;
      alu_done_o <= last_q && (wb.gnt || st_valid_o);
      if (alu_start_i) begin
        active_q  <= 1'b1;
        pop_cnt_q <= '0;
        last_q    <= 1'b0;
      end else if (alu_done_o) begin
        active_q <= 1'b0;
      end
      if (pop) begin
        pop_cnt_q <= pop_cnt_q + 1'b1;
        last_q    <= (pop_cnt_q + vl_t'(1)) == vl_q;
      end
      if (pop && !is_store) wb_req_q <= 1'b1;
      else if (wb.gnt)      wb_req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_start_i) begin
      op_q <= alu_op_i;
      vd_q <= alu_vd_i;
      vl_q <= alu_vl_i;
    end
    if (pop) begin
      wb_bank_q <= bank_of(vd_q, elem_idx_t'(pop_cnt_q));
      wb_row_q  <= row_of(vd_q, elem_idx_t'(pop_cnt_q));
      wb_data_q <= result;
      st_data_o <= opb_i;
    end
  end

  assign wb.req   = wb_req_q;
  assign wb.wen   = 1'b1;
  assign wb.bank  = wb_bank_q;
  assign wb.row   = wb_row_q;
  assign wb.wdata = wb_data_q;
  assign wb.tgt   = OPQ_A;

endmodule

/* src/vector_regfile.sv */
/* Each bank does one access per cycle. Read data appears one cycle after the grant,
   tagged with its queue, on the first free output lane. */
`timescale 1ns/1ps

module vector_regfile import lane_pkg::*; #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic  [NrBanks-1:0] req_i,
  input  logic  [NrBanks-1:0] wen_i,
  input  row_t  [NrBanks-1:0] row_i,
  input  elem_t [NrBanks-1:0] wdata_i,
  input  opq_e  [NrBanks-1:0] tgt_i,
  output elem_t [1:0]         rdata_o,
  output logic  [1:0]         rdata_valid_o,
  output opq_e  [1:0]         rdata_tgt_o
);

  localparam int unsigned NrRows = NrVRegs * MaxVl / NrBanks;

  elem_t                mem_q [NrBanks][NrRows];
  logic  [NrBanks-1:0]  rd_q;
  elem_t [NrBanks-1:0]  rd_data_q;
  opq_e  [NrBanks-1:0]  rd_tgt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rd_q <= '0;
    else         rd_q <= req_i & ~wen_i;
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NrBanks; b++) begin
      if (req_i[b] && wen_i[b]) mem_q[b][row_i[b]] <= wdata_i[b];
      if (req_i[b] && !wen_i[b]) begin
        rd_data_q[b] <= mem_q[b][row_i[b]];
        rd_tgt_q[b]  <= tgt_i[b];
      end
    end
  end

  // Streams A and B each have at most one read in flight per cycle
  always_comb begin
    logic lane_sel;
    lane_sel       = 1'b0;
    rdata_o        = '0;
    rdata_valid_o  = '0;
    rdata_tgt_o[0] = OPQ_A;
    rdata_tgt_o[1] = OPQ_B;
    for (int b = 0; b < NrBanks; b++) begin
      if (rd_q[b]) begin
        rdata_o[lane_sel]       = rd_data_q[b];
        rdata_valid_o[lane_sel] = 1'b1;
        rdata_tgt_o[lane_sel]   = rd_tgt_q[b];
        lane_sel                = 1'b1;
      end
    end
  end

endmodule

/* src/vrf_req_if.sv */
/* One VRF bank access. The client holds its request until gnt, which comes back in the
   same cycle. tgt only matters for reads. */
`timescale 1ns/1ps

interface vrf_req_if import lane_pkg::*; ();

  logic  req;
  logic  wen;
  bank_t bank;
  row_t  row;
  elem_t wdata;
  opq_e  tgt;
  logic  gnt;

  modport client (
    output req, wen, bank, row, wdata, tgt,
    input  gnt
  );

  modport arbiter (
    input  req, wen, bank, row, wdata, tgt,
    output gnt
  );

endinterface

/* vlog.f */
src/lane_pkg.sv
src/vrf_req_if.sv
src/lane_sequencer.sv
src/operand_requester.sv
src/vector_regfile.sv
src/operand_queues.sv
src/vector_alu.sv
src/lane.sv
dv/lane_tb.sv
